/* logic/mbus_pkg.sv */
package mbus_pkg;

	// Register index carried in a message, also used as reply address
	localparam int MBUS_ADDR_WIDTH = 8;

	// Payload of one message
	localparam int MBUS_DATA_WIDTH = 24;

	// Field layout of a received message, as seen by the layer
	//   rx_read  selects read or write
	//   rx_addr  register index, MBUS_ADDR_WIDTH bits
	//   rx_data  write value, MBUS_DATA_WIDTH bits
	//   rx_prio  priority to use on the reply
	// A reply carries the same index in tx_addr and the register value in tx_data

endpackage

/* logic/lc_pkg.sv */
package lc_pkg;

	// Register file geometry
	localparam int LC_RF_DEPTH = 16;
	localparam int LC_RF_ADDR_WIDTH = $clog2(LC_RF_DEPTH);

	// Same as the bus data width
	localparam int LC_RF_DATA_WIDTH = 24;

	// Isolation level that clamps the controller outputs
	localparam logic LC_IO_HOLD = 1'b1;

	// Power sequencer states
	typedef enum logic [2:0]
	{
		ASLEEP  = 3'd0,
		PWR_ON  = 3'd1,
		RST_OFF = 3'd2,
		AWAKE   = 3'd3,
		ISO_ON  = 3'd4,
		RST_ON  = 3'd5
	} lc_pwr_state_t;

endpackage

/* logic/lc_power_ctrl.sv */
`timescale 1ns/100ps

module lc_power_ctrl
	import lc_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic sleep_req,
	input  logic wake_req,
	input  logic lc_busy,
	output logic lc_isolation,
	output logic lc_reset_n,
	output logic lc_power_on,
	output logic layer_awake
);

	lc_pwr_state_t state;
	lc_pwr_state_t state_nxt;
	logic sleep_pend;
	logic sleep_go;

	// Sleep waits for the controller to finish its reply
	assign sleep_go = (sleep_req | sleep_pend) & ~lc_busy;

	always_comb
	begin
		state_nxt = state;
		case (state)
			ASLEEP:  if (wake_req) state_nxt = PWR_ON;
			PWR_ON:  state_nxt = RST_OFF;
			RST_OFF: state_nxt = AWAKE;
			AWAKE:   if (sleep_go) state_nxt = ISO_ON;
			ISO_ON:  state_nxt = RST_ON;
			RST_ON:  state_nxt = ASLEEP;
			default: state_nxt = ASLEEP;
		endcase
	end

	// Remember a sleep request until the domain can go down
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			sleep_pend <= 1'b0;
		else if (state_nxt == ISO_ON)
			sleep_pend <= 1'b0;
		else if (sleep_req && (state inside {PWR_ON, RST_OFF, AWAKE}))
			sleep_pend <= 1'b1;
	end

	// Outputs follow the next state so they change with the state register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state        <= ASLEEP;
			lc_isolation <= LC_IO_HOLD;
			lc_reset_n   <= 1'b0;
			lc_power_on  <= 1'b0;
			layer_awake  <= 1'b0;
		end
		else
		begin
			state        <= state_nxt;
			lc_isolation <= (state_nxt == AWAKE) ? ~LC_IO_HOLD : LC_IO_HOLD;
			lc_reset_n   <= state_nxt inside {RST_OFF, AWAKE, ISO_ON};
			lc_power_on  <= (state_nxt != ASLEEP);
			layer_awake  <= (state_nxt == AWAKE);
		end
	end

endmodule

/* logic/layer_ctrl.sv */
`timescale 1ns/100ps

module layer_ctrl
	import mbus_pkg::*, lc_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        lc_reset_n,
	input  logic                        rx_req,
	input  logic                        rx_read,
	input  logic [MBUS_ADDR_WIDTH-1:0]  rx_addr,
	input  logic [MBUS_DATA_WIDTH-1:0]  rx_data,
	input  logic                        rx_prio,
	input  logic                        tx_ack,
	input  logic [LC_RF_DATA_WIDTH-1:0] rf_rdata,
	output logic                        rx_ack,
	output logic                        tx_req,
	output logic [MBUS_ADDR_WIDTH-1:0]  tx_addr,
	output logic [MBUS_DATA_WIDTH-1:0]  tx_data,
	output logic                        tx_priority,
	output logic [LC_RF_DEPTH-1:0]      rf_load,
	output logic [LC_RF_DATA_WIDTH-1:0] rf_data,
	output logic [MBUS_ADDR_WIDTH-1:0]  rf_raddr,
	output logic                        lc_busy
);

	logic ctrl_rst_n;
	logic accept;
	logic in_range;
	logic rd_pend;
	logic [LC_RF_DEPTH-1:0] load_dec;

	// Domain reset from the sequencer or the global reset
	assign ctrl_rst_n = rst_n & lc_reset_n;

	// No new message while a reply is in flight
	assign accept = rx_req & ~rd_pend & ~tx_req;
	assign in_range = (rx_addr < MBUS_ADDR_WIDTH'(LC_RF_DEPTH));

	always_comb
	begin
		load_dec = '0;
		if (accept && !rx_read && in_range)
			load_dec[rx_addr[LC_RF_ADDR_WIDTH-1:0]] = 1'b1;
	end

	always_ff @(posedge clk or negedge ctrl_rst_n)
	begin
		if (!ctrl_rst_n)
		begin
			rx_ack  <= 1'b0;
			rf_load <= '0;
			rd_pend <= 1'b0;
			tx_req  <= 1'b0;
		end
		else
		begin
			rx_ack  <= accept;
			rf_load <= load_dec;
			rd_pend <= accept & rx_read;
			if (rd_pend)
				tx_req <= 1'b1;
			else if (tx_ack)
				tx_req <= 1'b0;
		end
	end

	// Message payload and reply fields
	always_ff @(posedge clk or negedge ctrl_rst_n)
	begin
		if (!ctrl_rst_n)
		begin
			rf_data     <= '0;
			tx_addr     <= '0;
			tx_priority <= 1'b0;
			tx_data     <= '0;
		end
		else
		begin
			if (accept && !rx_read)
				rf_data <= rx_data;
			if (accept && rx_read)
			begin
				tx_addr     <= rx_addr;
				tx_priority <= rx_prio;
			end
			if (rd_pend)
				tx_data <= rf_rdata;
		end
	end

	// Read index stays on tx_addr for the whole reply
	assign rf_raddr = tx_addr;
	assign lc_busy = rd_pend | tx_req;

endmodule

/* logic/layer_ctrl_isolation.sv */
`timescale 1ns/100ps

module layer_ctrl_isolation
	import mbus_pkg::*, lc_pkg::*;
(
	input  logic                        lc_isolation,
	input  logic                        tx_req_from_lc,
	input  logic [MBUS_ADDR_WIDTH-1:0]  tx_addr_from_lc,
	input  logic [MBUS_DATA_WIDTH-1:0]  tx_data_from_lc,
	input  logic                        tx_priority_from_lc,
	input  logic                        rx_ack_from_lc,
	input  logic [LC_RF_DEPTH-1:0]      rf_load_from_lc,
	input  logic [LC_RF_DATA_WIDTH-1:0] rf_data_from_lc,
	output logic                        tx_req_to_mbus,
	output logic [MBUS_ADDR_WIDTH-1:0]  tx_addr_to_mbus,
	output logic [MBUS_DATA_WIDTH-1:0]  tx_data_to_mbus,
	output logic                        tx_priority_to_mbus,
	output logic                        rx_ack_to_mbus,
	output logic [LC_RF_DEPTH-1:0]      rf_load_to_rf,
	output logic [LC_RF_DATA_WIDTH-1:0] rf_data_to_rf
);

	// Bus side
	always_comb
	begin
		if (lc_isolation == LC_IO_HOLD)
		begin
			tx_req_to_mbus      = 1'b0;
			tx_addr_to_mbus     = '0;
			tx_data_to_mbus     = '0;
			tx_priority_to_mbus = 1'b0;
			rx_ack_to_mbus      = 1'b0;
		end
		else
		begin
			tx_req_to_mbus      = tx_req_from_lc;
			tx_addr_to_mbus     = tx_addr_from_lc;
			tx_data_to_mbus     = tx_data_from_lc;
			tx_priority_to_mbus = tx_priority_from_lc;
			rx_ack_to_mbus      = rx_ack_from_lc;
		end
	end

	// Register file side, keeps loads off while the domain is down
	always_comb
	begin
		if (lc_isolation == LC_IO_HOLD)
		begin
			rf_load_to_rf = '0;
			rf_data_to_rf = '0;
		end
		else
		begin
			rf_load_to_rf = rf_load_from_lc;
			rf_data_to_rf = rf_data_from_lc;
		end
	end

endmodule

/* logic/layer_reg_file.sv */
`timescale 1ns/100ps

module layer_reg_file
	import mbus_pkg::*, lc_pkg::*;
(
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [LC_RF_DEPTH-1:0]      rf_load,
	input  logic [LC_RF_DATA_WIDTH-1:0] rf_data,
	input  logic [MBUS_ADDR_WIDTH-1:0]  rf_raddr,
	output logic [LC_RF_DATA_WIDTH-1:0] rf_rdata
);

	logic [LC_RF_DATA_WIDTH-1:0] regs [LC_RF_DEPTH];

	// Always-on storage, survives controller power-down
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < LC_RF_DEPTH; i++)
				regs[i] <= '0;
		end
		else
		begin
			for (int i = 0; i < LC_RF_DEPTH; i++)
				if (rf_load[i])
					regs[i] <= rf_data;
		end
	end

	// Out of range reads as zero
	assign rf_rdata = (rf_raddr < MBUS_ADDR_WIDTH'(LC_RF_DEPTH)) ?
		regs[rf_raddr[LC_RF_ADDR_WIDTH-1:0]] : '0;

endmodule

/* logic/layer_top.sv */
`timescale 1ns/100ps

module layer_top
	import mbus_pkg::*, lc_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       sleep_req,
	input  logic                       wake_req,
	input  logic                       rx_req,
	input  logic                       rx_read,
	input  logic [MBUS_ADDR_WIDTH-1:0] rx_addr,
	input  logic [MBUS_DATA_WIDTH-1:0] rx_data,
	input  logic                       rx_prio,
	output logic                       rx_ack,
	output logic                       tx_req,
	output logic [MBUS_ADDR_WIDTH-1:0] tx_addr,
	output logic [MBUS_DATA_WIDTH-1:0] tx_data,
	output logic                       tx_priority,
	input  logic                       tx_ack,
	output logic                       layer_awake
);

	logic lc_isolation;
	logic lc_reset_n;
	logic lc_busy;

	// Raw controller outputs
	logic                        lc_rx_ack;
	logic                        lc_tx_req;
	logic [MBUS_ADDR_WIDTH-1:0]  lc_tx_addr;
	logic [MBUS_DATA_WIDTH-1:0]  lc_tx_data;
	logic                        lc_tx_priority;
	logic [LC_RF_DEPTH-1:0]      lc_rf_load;
	logic [LC_RF_DATA_WIDTH-1:0] lc_rf_data;

	logic [LC_RF_DEPTH-1:0]      rf_load;
	logic [LC_RF_DATA_WIDTH-1:0] rf_data;
	logic [MBUS_ADDR_WIDTH-1:0]  rf_raddr;
	logic [LC_RF_DATA_WIDTH-1:0] rf_rdata;

	lc_power_ctrl u_power_ctrl (
		.clk          (clk),
		.rst_n        (rst_n),
		.sleep_req    (sleep_req),
		.wake_req     (wake_req),
		.lc_busy      (lc_busy),
		.lc_isolation (lc_isolation),
		.lc_reset_n   (lc_reset_n),
		// Header switch control lives outside this block
		.lc_power_on  (),
		.layer_awake  (layer_awake)
	);

	layer_ctrl u_layer_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.lc_reset_n  (lc_reset_n),
		.rx_req      (rx_req),
		.rx_read     (rx_read),
		.rx_addr     (rx_addr),
		.rx_data     (rx_data),
		.rx_prio     (rx_prio),
		.tx_ack      (tx_ack),
		.rf_rdata    (rf_rdata),
		.rx_ack      (lc_rx_ack),
		.tx_req      (lc_tx_req),
		.tx_addr     (lc_tx_addr),
		.tx_data     (lc_tx_data),
		.tx_priority (lc_tx_priority),
		.rf_load     (lc_rf_load),
		.rf_data     (lc_rf_data),
		.rf_raddr    (rf_raddr),
		.lc_busy     (lc_busy)
	);

	layer_ctrl_isolation u_isolation (
		.lc_isolation        (lc_isolation),
		.tx_req_from_lc      (lc_tx_req),
		.tx_addr_from_lc     (lc_tx_addr),
		.tx_data_from_lc     (lc_tx_data),
		.tx_priority_from_lc (lc_tx_priority),
		.rx_ack_from_lc      (lc_rx_ack),
		.rf_load_from_lc     (lc_rf_load),
		.rf_data_from_lc     (lc_rf_data),
		.tx_req_to_mbus      (tx_req),
		.tx_addr_to_mbus     (tx_addr),
		.tx_data_to_mbus     (tx_data),
		.tx_priority_to_mbus (tx_priority),
		.rx_ack_to_mbus      (rx_ack),
		.rf_load_to_rf       (rf_load),
		.rf_data_to_rf       (rf_data)
	);

	layer_reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rf_load  (rf_load),
		.rf_data  (rf_data),
		.rf_raddr (rf_raddr),
		.rf_rdata (rf_rdata)
	);

endmodule

/* verif/tb_layer_tasks.svh */
// Galois LFSR, right shifting
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	if (s[0])
		return (s >> 1) ^ 32'h80200003;
	else
		return s >> 1;
endfunction

// One LFSR step per bit
task automatic take_bits(input int n, output logic [31:0] v);
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsr = lfsr_next(lfsr);
		v = {v[30:0], lfsr[0]};
	end
endtask

task automatic send_msg(input logic rd, input logic [MBUS_ADDR_WIDTH-1:0] idx,
	input logic [MBUS_DATA_WIDTH-1:0] data, input logic prio, input logic ack_due);
	@(posedge clk);
	rx_req  <= 1'b1;
	rx_read <= rd;
	rx_addr <= idx;
	rx_data <= data;
	rx_prio <= prio;
	@(posedge clk);
	rx_req <= 1'b0;
	// Ack belongs to the cycle right after the request
	@(negedge clk);
	if (rx_ack !== ack_due)
		report_value("rx_ack", 32'(ack_due), 32'(rx_ack));
	@(negedge clk);
	if (rx_ack !== 1'b0)
		report_value("rx_ack pulse end", 0, 32'(rx_ack));
endtask

task automatic do_write(input logic [MBUS_ADDR_WIDTH-1:0] idx,
	input logic [LC_RF_DATA_WIDTH-1:0] data);
	send_msg(1'b0, idx, data, 1'b0, 1'b1);
	if (int'(idx) < LC_RF_DEPTH)
		model[idx[LC_RF_ADDR_WIDTH-1:0]] = data;
endtask

task automatic issue_read(input logic [MBUS_ADDR_WIDTH-1:0] idx, input logic prio);
	int n;
	exp_idx = idx;
	exp_prio = prio;
	read_open = 1'b1;
	send_msg(1'b1, idx, '0, prio, 1'b1);
	n = 0;
	while (tx_req !== 1'b1 && n < 16)
	begin
		@(negedge clk);
		n++;
	end
	if (tx_req !== 1'b1)
		report_fail("no transmit request after a read");
endtask

task automatic ack_reply(input int delay);
	repeat (delay) @(posedge clk);
	@(posedge clk);
	tx_ack <= 1'b1;
	@(posedge clk);
	tx_ack <= 1'b0;
	@(negedge clk);
	if (tx_req !== 1'b0)
		report_fail("tx_req still high after tx_ack");
	read_open = 1'b0;
endtask

task automatic do_read(input logic [MBUS_ADDR_WIDTH-1:0] idx, input logic prio,
	input int delay);
	issue_read(idx, prio);
	ack_reply(delay);
endtask

task automatic read_all;
	logic [31:0] p;
	for (int i = 0; i < LC_RF_DEPTH; i++)
	begin
		take_bits(1, p);
		do_read(MBUS_ADDR_WIDTH'(i), p[0], 0);
	end
endtask

task automatic wait_awake(input logic level, output int n);
	n = 0;
	do
	begin
		@(negedge clk);
		n++;
	end
	while (layer_awake !== level && n < 32);
	if (layer_awake !== level)
		report_fail("timed out waiting for layer_awake to change");
endtask

task automatic wake_layer;
	int n;
	@(posedge clk);
	wake_req <= 1'b1;
	@(posedge clk);
	wake_req <= 1'b0;
	wait_awake(1'b1, n);
	// Three sequencer steps from the drive edge
	if (n != 3)
		report_value("wake latency", 3, n);
endtask

task automatic sleep_layer;
	int n;
	@(posedge clk);
	sleep_req <= 1'b1;
	@(posedge clk);
	sleep_req <= 1'b0;
	wait_awake(1'b0, n);
	if (n != 1)
		report_value("sleep latency", 1, n);
endtask

/* verif/tb_layer_top.sv */
`timescale 1ns/100ps

module tb_layer_top
	import mbus_pkg::*, lc_pkg::*;
();

	localparam logic [31:0] SEED = 32'h448ba34a;
	localparam int RESET_CYCLES = 16;
	localparam int N_WRITES = 24;
	localparam int MAX_HOLD = 17;
	// Reads in tests 2 to 6, and the writes plus dropped messages
	localparam int N_READS = 4 * LC_RF_DEPTH + 6;
	localparam int N_OTHER = N_WRITES + 20;
	// A message takes about 4 cycles, a read about 10 plus its hold
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 4 * N_OTHER + 10 * N_READS
		+ 5 * MAX_HOLD + 200;

	logic                       clk;
	logic                       rst_n;
	logic                       sleep_req;
	logic                       wake_req;
	logic                       rx_req;
	logic                       rx_read;
	logic [MBUS_ADDR_WIDTH-1:0] rx_addr;
	logic [MBUS_DATA_WIDTH-1:0] rx_data;
	logic                       rx_prio;
	logic                       rx_ack;
	logic                       tx_req;
	logic [MBUS_ADDR_WIDTH-1:0] tx_addr;
	logic [MBUS_DATA_WIDTH-1:0] tx_data;
	logic                       tx_priority;
	logic                       tx_ack;
	logic                       layer_awake;

	// Reference state
	logic [LC_RF_DATA_WIDTH-1:0] model [LC_RF_DEPTH];
	logic [31:0]                 lfsr;
	logic [MBUS_ADDR_WIDTH-1:0]  exp_idx;
	logic                        exp_prio;
	logic                        read_open = 1'b0;

	string cur_test = "init";
	int error_count = 0;
	int reply_errors = 0;
	int errs_before = 0;
	int tests_run = 0;
	int tests_failed = 0;

	layer_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [LC_RF_DATA_WIDTH-1:0] expected_reply(
		input logic [MBUS_ADDR_WIDTH-1:0] idx);
		if (int'(idx) < LC_RF_DEPTH)
			return model[idx[LC_RF_ADDR_WIDTH-1:0]];
		else
			return '0;
	endfunction

	task automatic report_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		$display("error %s %s: expected %0h actual %0h", cur_test, what, expected, actual);
	endtask

	task automatic report_fail(input string what);
		error_count++;
		$display("%s failed: %s", cur_test, what);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		errs_before = error_count + reply_errors;
	endtask

	task automatic end_test;
		int errs;
		errs = error_count + reply_errors - errs_before;
		tests_run++;
		if (errs == 0)
			$display("test %s: ok", cur_test);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errs);
		end
	endtask

	`include "tb_layer_tasks.svh"

	// Every cycle of a reply is compared, so held fields are covered too
	always @(negedge clk)
	begin
		if (rst_n && tx_req)
		begin
			if (!read_open)
			begin
				reply_errors++;
				$display("%s failed: transmit request with no read outstanding", cur_test);
			end
			else if (tx_addr !== exp_idx || tx_data !== expected_reply(exp_idx)
				|| tx_priority !== exp_prio)
			begin
				reply_errors++;
				$display("error %s reply addr/data/prio: expected %h/%h/%b actual %h/%h/%b",
					cur_test, exp_idx, expected_reply(exp_idx), exp_prio,
					tx_addr, tx_data, tx_priority);
			end
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] r;
		logic [31:0] d;
		int n;
		rst_n     <= 1'b0;
		sleep_req <= 1'b0;
		wake_req  <= 1'b0;
		rx_req    <= 1'b0;
		rx_read   <= 1'b0;
		rx_addr   <= '0;
		rx_data   <= '0;
		rx_prio   <= 1'b0;
		tx_ack    <= 1'b0;
		lfsr = SEED;
		for (int i = 0; i < LC_RF_DEPTH; i++)
			model[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		begin_test("reset_asleep");
		@(negedge clk);
		if (layer_awake !== 1'b0 || rx_ack !== 1'b0 || tx_req !== 1'b0)
			report_fail("layer not quiet and asleep after reset");
		send_msg(1'b0, 8'd3, 24'h5a5a5a, 1'b0, 1'b0);
		send_msg(1'b1, 8'd3, '0, 1'b1, 1'b0);
		end_test();

		begin_test("wake_write_read");
		wake_layer();
		for (int i = 0; i < N_WRITES; i++)
		begin
			take_bits(LC_RF_ADDR_WIDTH, r);
			take_bits(LC_RF_DATA_WIDTH, d);
			do_write(MBUS_ADDR_WIDTH'(r), LC_RF_DATA_WIDTH'(d));
		end
		read_all();
		end_test();

		begin_test("out_of_range");
		take_bits(7, r);
		take_bits(LC_RF_DATA_WIDTH, d);
		do_write(MBUS_ADDR_WIDTH'(LC_RF_DEPTH + int'(r[6:0])), LC_RF_DATA_WIDTH'(d));
		do_read(MBUS_ADDR_WIDTH'(LC_RF_DEPTH + int'(r[6:0])), 1'b1, 0);
		read_all();
		end_test();

		begin_test("back_pressure");
		for (int k = 0; k < 4; k++)
		begin
			take_bits(LC_RF_ADDR_WIDTH + 1, r);
			issue_read(MBUS_ADDR_WIDTH'(r[LC_RF_ADDR_WIDTH-1:0]), r[LC_RF_ADDR_WIDTH]);
			take_bits(LC_RF_DATA_WIDTH, d);
			// Both dropped while the reply waits
			send_msg(1'b0, MBUS_ADDR_WIDTH'(k), LC_RF_DATA_WIDTH'(d), 1'b0, 1'b0);
			send_msg(1'b1, MBUS_ADDR_WIDTH'(k + 4), '0, 1'b0, 1'b0);
			take_bits(4, r);
			ack_reply(int'(r[3:0]));
		end
		read_all();
		end_test();

		begin_test("sleep_retain");
		sleep_layer();
		for (int k = 0; k < 4; k++)
		begin
			take_bits(LC_RF_DATA_WIDTH, d);
			send_msg(1'b0, MBUS_ADDR_WIDTH'(k), LC_RF_DATA_WIDTH'(d), 1'b0, 1'b0);
			send_msg(1'b1, MBUS_ADDR_WIDTH'(k), '0, 1'b0, 1'b0);
		end
		wake_layer();
		read_all();
		end_test();

		begin_test("sleep_while_busy");
		take_bits(LC_RF_ADDR_WIDTH + 1, r);
		issue_read(MBUS_ADDR_WIDTH'(r[LC_RF_ADDR_WIDTH-1:0]), r[LC_RF_ADDR_WIDTH]);
		@(posedge clk);
		sleep_req <= 1'b1;
		@(posedge clk);
		sleep_req <= 1'b0;
		take_bits(4, r);
		repeat (int'(r[3:0]) + 2)
		begin
			@(negedge clk);
			if (layer_awake !== 1'b1)
				report_fail("layer went to sleep with a reply pending");
		end
		ack_reply(0);
		if (layer_awake !== 1'b1)
			report_fail("layer asleep in the cycle the reply completed");
		wait_awake(1'b0, n);
		if (n != 1)
			report_value("sleep latency", 1, n);
		end_test();

		$display("tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, error_count + reply_errors);
		if (tests_failed == 0 && error_count + reply_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* files.f */
+incdir+verif
logic/mbus_pkg.sv
logic/lc_pkg.sv
logic/lc_power_ctrl.sv
logic/layer_ctrl.sv
logic/layer_ctrl_isolation.sv
logic/layer_reg_file.sv
logic/layer_top.sv
verif/tb_layer_top.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_layer_top
FILELIST  = files.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
HDRS = verif/tb_layer_tasks.svh

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
